/* common/qr_pkg.sv */
package qr_pkg;

	localparam int R_LEN    = 12;
	localparam int ROW_LEN  = 3;
	localparam int K_LEN    = 10;
	localparam int K_FRAC   = 9;
	localparam int ITER_LEN = 4;

	// CORDIC gain, about 0.607 in Q0.9
	localparam logic signed [K_LEN-1:0] K_VALUE = 10'sd311;

	typedef logic signed [R_LEN-1:0] sample_t;

	typedef struct packed {
		logic [ROW_LEN-1:0] row;
		logic               col;
	} mat_addr_t;

	typedef struct packed {
		sample_t a1;
		sample_t a2;
	} a_row_t;

	typedef struct packed {
		logic                load;
		logic                step;
		logic                scale;
		logic [ITER_LEN-1:0] iter;
	} cordic_ctl_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		ROT,
		MUL_K,
		DONE
	} qr_state_e;

	// One micro-rotation, dir high when y >= 0 in the vectoring cell
	function automatic void micro_rot(
		input  sample_t             x,
		input  sample_t             y,
		input  logic                dir,
		input  logic [ITER_LEN-1:0] sh,
		output sample_t             x_new,
		output sample_t             y_new
	);
		if (dir) begin
			x_new = x + (y >>> sh);
			y_new = y - (x >>> sh);
		end else begin
			x_new = x - (y >>> sh);
			y_new = y + (x >>> sh);
		end
	endfunction

	// Gain compensation, truncated back to sample width
	function automatic sample_t scale_k(input sample_t v);
		logic signed [R_LEN+K_LEN-1:0] prod;
		prod = v * K_VALUE;
		return sample_t'(prod >>> K_FRAC);
	endfunction

endpackage

/* cordic_array/givens_generate.sv */
module givens_generate
	import qr_pkg::*;
#(
	parameter int ITER_NUM = 12
)
(
	input  logic        clk,
	input  logic        rst,
	input  cordic_ctl_t ctl,
	input  sample_t     y_in,
	output logic        dir,
	output sample_t     x_out
);

	sample_t x_q;
	sample_t y_q;
	sample_t y_src;
	sample_t x_rot;
	sample_t y_rot;

	// A new row enters on the first step of its slot
	always_comb begin
		y_src = ctl.load ? y_in : y_q;
		dir   = ~y_src[R_LEN-1];
		micro_rot(x_q, y_src, dir, ctl.iter, x_rot, y_rot);
	end

	// x carries the running norm from row to row
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x_q <= '0;
			y_q <= '0;
		end else if (ctl.step) begin
			x_q <= x_rot;
			y_q <= y_rot;
		end else if (ctl.scale) begin
			x_q <= scale_k(x_q);
			y_q <= scale_k(y_q);
		end else if (ctl.load) begin
			// Load outside ROT starts a new matrix
			x_q <= '0;
			y_q <= y_in;
		end
	end

	assign x_out = x_q;

	// Every row gets the full set of micro-rotations, then one K step
	gen_slot: assert property (@(posedge clk) disable iff (rst)
		ctl.load && ctl.step |-> ctl.step [*ITER_NUM] ##1 ctl.scale);

endmodule

/* cordic_array/givens_rotate.sv */
module givens_rotate
	import qr_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  cordic_ctl_t ctl,
	input  logic        dir,
	input  sample_t     y_in,
	output sample_t     x_out,
	output sample_t     y_out
);

	sample_t x_q;
	sample_t y_q;
	sample_t y_src;
	sample_t x_rot;
	sample_t y_rot;

	// Direction comes from the vectoring cell in the same cycle
	always_comb begin
		y_src = ctl.load ? y_in : y_q;
		micro_rot(x_q, y_src, dir, ctl.iter, x_rot, y_rot);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x_q <= '0;
			y_q <= '0;
		end else if (ctl.step) begin
			x_q <= x_rot;
			y_q <= y_rot;
		end else if (ctl.scale) begin
			x_q <= scale_k(x_q);
			y_q <= scale_k(y_q);
		end else if (ctl.load) begin
			x_q <= '0;
			y_q <= y_in;
		end
	end

	// Running r12
	assign x_out = x_q;
	// Scaled residual stays put until the next row loads,
	// which is the cycle the residual cell picks it up
	assign y_out = y_q;

endmodule

/* cordic_array/qr_sequencer.sv */
module qr_sequencer
	import qr_pkg::*;
#(
	parameter int ROWS     = 8,
	parameter int ITER_NUM = 12
)
(
	input  logic               clk,
	input  logic               rst,
	input  logic               en,
	output cordic_ctl_t        ctl_col1,
	output cordic_ctl_t        ctl_r22,
	output logic               fetch,
	output logic [ROW_LEN-1:0] fetch_row,
	output logic               col1_done,
	output logic               all_done
);

	// Row 0 needs three cycles from fetch to a full row register
	localparam int LOAD_CYCLES = 3;
	localparam logic [ROW_LEN:0] LAST_SLOT = (ROW_LEN+1)'(ROWS);

	qr_state_e           state;
	logic [ITER_LEN-1:0] iter;
	logic [ROW_LEN:0]    slot;
	logic                load_last;
	logic                slot_first;
	logic                col1_act;
	logic                r22_act;

	assign load_last  = (state == LOAD) && (iter == ITER_LEN'(LOAD_CYCLES - 1));
	assign slot_first = (state == ROT) && (iter == '0);
	// Column 1 runs in slots 0..ROWS-1, the residual cell in 1..ROWS
	assign col1_act   = int'(slot) < ROWS;
	assign r22_act    = slot != '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			iter  <= '0;
			slot  <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (en) begin
						state <= LOAD;
						iter  <= '0;
						slot  <= '0;
					end
				end
				LOAD: begin
					if (load_last) begin
						state <= ROT;
						iter  <= '0;
					end else begin
						iter <= iter + 1'b1;
					end
				end
				ROT: begin
					if (iter == ITER_LEN'(ITER_NUM - 1)) begin
						state <= MUL_K;
						iter  <= '0;
					end else begin
						iter <= iter + 1'b1;
					end
				end
				MUL_K: begin
					if (slot == LAST_SLOT) begin
						state <= DONE;
					end else begin
						state <= ROT;
						slot  <= slot + 1'b1;
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Next row is read during the first cycles of the current slot
	assign fetch     = ((state == LOAD) && (iter == '0)) ||
	                   (slot_first && (int'(slot) + 1 < ROWS));
	assign fetch_row = (state == LOAD) ? '0 : ROW_LEN'(slot + 1'b1);

	always_comb begin
		ctl_col1.load  = load_last || (slot_first && col1_act);
		ctl_col1.step  = (state == ROT) && col1_act;
		ctl_col1.scale = (state == MUL_K) && col1_act;
		ctl_col1.iter  = iter;

		ctl_r22.load  = load_last || (slot_first && r22_act);
		ctl_r22.step  = (state == ROT) && r22_act;
		ctl_r22.scale = (state == MUL_K) && r22_act;
		ctl_r22.iter  = iter;
	end

	// First cycle after the last column 1 scale
	assign col1_done = slot_first && (slot == LAST_SLOT);
	assign all_done  = state == DONE;

	seq_iter: assert property (@(posedge clk) disable iff (rst)
		(state == ROT) |-> (iter < ITER_NUM));

endmodule

/* qr_cordic.f */
common/qr_pkg.sv
src/a_reader.sv
cordic_array/givens_generate.sv
cordic_array/givens_rotate.sv
cordic_array/qr_sequencer.sv
src/r_writer.sv
src/qr_cordic_top.sv
testbench/tb_qr_cordic.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the QR CORDIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_qr_cordic

rm -rf obj_dir "$LOG"

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_qr_cordic -f qr_cordic.f -o "$BIN"; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation run returned an error"
	exit 1
fi

cat "$LOG"

if grep -q "^Simulation PASSED$" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

/* src/a_reader.sv */
module a_reader
	import qr_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               fetch,
	input  logic [ROW_LEN-1:0] fetch_row,
	input  sample_t            rd_a_data,
	output logic               rd_a,
	output mat_addr_t          rd_a_addr,
	output a_row_t             row_out
);

	// High while the col 1 read is on the bus
	logic               second;
	// High while the col 1 sample comes back
	logic               cap_a2;
	logic [ROW_LEN-1:0] row_q;

	// Col 0 goes out with fetch itself, col 1 one cycle later
	assign rd_a = fetch | second;

	always_comb begin
		rd_a_addr.row = fetch ? fetch_row : row_q;
		rd_a_addr.col = second;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			second <= 1'b0;
			cap_a2 <= 1'b0;
		end else begin
			second <= fetch;
			cap_a2 <= second;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch) begin
			row_q <= fetch_row;
		end
		// The col 0 sample returns while the col 1 read is issued
		if (second) begin
			row_out.a1 <= rd_a_data;
		end
		if (cap_a2) begin
			row_out.a2 <= rd_a_data;
		end
	end

	a_rd_burst: assert property (@(posedge clk) disable iff (rst)
		rd_a ##1 rd_a |=> !rd_a);

endmodule

/* src/qr_cordic_top.sv */
module qr_cordic_top
	import qr_pkg::*;
#(
	parameter int ROWS     = 8,
	parameter int ITER_NUM = 12
)
(
	input  logic      clk,
	input  logic      rst,
	input  logic      en,
	input  sample_t   rd_a_data,
	output logic      rd_a,
	output mat_addr_t rd_a_addr,
	output logic      wr_r,
	output mat_addr_t wr_r_addr,
	output sample_t   wr_r_data,
	output logic      valid
);

	cordic_ctl_t        ctl_col1;
	cordic_ctl_t        ctl_r22;
	logic               fetch;
	logic [ROW_LEN-1:0] fetch_row;
	logic               col1_done;
	logic               all_done;
	a_row_t             a_row;
	logic               dir;
	sample_t            r11;
	sample_t            r12;
	sample_t            resid;
	sample_t            r22;

	qr_sequencer #(
		.ROWS     (ROWS),
		.ITER_NUM (ITER_NUM)
	) qr_sequencer_inst (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.ctl_col1  (ctl_col1),
		.ctl_r22   (ctl_r22),
		.fetch     (fetch),
		.fetch_row (fetch_row),
		.col1_done (col1_done),
		.all_done  (all_done)
	);

	a_reader a_reader_inst (
		.clk       (clk),
		.rst       (rst),
		.fetch     (fetch),
		.fetch_row (fetch_row),
		.rd_a_data (rd_a_data),
		.rd_a      (rd_a),
		.rd_a_addr (rd_a_addr),
		.row_out   (a_row)
	);

	// Column 1 pair
	givens_generate #(
		.ITER_NUM (ITER_NUM)
	) r11_inst (
		.clk   (clk),
		.rst   (rst),
		.ctl   (ctl_col1),
		.y_in  (a_row.a1),
		.dir   (dir),
		.x_out (r11)
	);

	givens_rotate r12_inst (
		.clk   (clk),
		.rst   (rst),
		.ctl   (ctl_col1),
		.dir   (dir),
		.y_in  (a_row.a2),
		.x_out (r12),
		.y_out (resid)
	);

	// Residual cell, one row behind
	givens_generate #(
		.ITER_NUM (ITER_NUM)
	) r22_inst (
		.clk   (clk),
		.rst   (rst),
		.ctl   (ctl_r22),
		.y_in  (resid),
		.dir   (),
		.x_out (r22)
	);

	r_writer r_writer_inst (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.col1_done (col1_done),
		.all_done  (all_done),
		.r11       (r11),
		.r12       (r12),
		.r22       (r22),
		.wr_r      (wr_r),
		.wr_r_addr (wr_r_addr),
		.wr_r_data (wr_r_data),
		.valid     (valid)
	);

endmodule

/* src/r_writer.sv */
module r_writer
	import qr_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      en,
	input  logic      col1_done,
	input  logic      all_done,
	input  sample_t   r11,
	input  sample_t   r12,
	input  sample_t   r22,
	output logic      wr_r,
	output mat_addr_t wr_r_addr,
	output sample_t   wr_r_data,
	output logic      valid
);

	sample_t r12_q;
	logic    r12_pend;
	// High during the r22 write
	logic    r22_wr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_r     <= 1'b0;
			r12_pend <= 1'b0;
			r22_wr   <= 1'b0;
			valid    <= 1'b0;
		end else begin
			wr_r     <= col1_done | r12_pend | all_done;
			r12_pend <= col1_done;
			r22_wr   <= all_done;
			if (en) begin
				valid <= 1'b0;
			end else if (r22_wr) begin
				valid <= 1'b1;
			end
		end
	end

	// r11 then r12 on back to back cycles, r22 at the very end
	always_ff @(posedge clk) begin
		if (col1_done) begin
			wr_r_addr <= '{row: '0, col: 1'b0};
			wr_r_data <= r11;
			r12_q     <= r12;
		end else if (r12_pend) begin
			wr_r_addr <= '{row: '0, col: 1'b1};
			wr_r_data <= r12_q;
		end else if (all_done) begin
			wr_r_addr <= '{row: ROW_LEN'(1), col: 1'b1};
			wr_r_data <= r22;
		end
	end

	wr_quiet: assert property (@(posedge clk) disable iff (rst)
		valid |-> !wr_r);

endmodule

/* testbench/tb_qr_cordic.sv */
module tb_qr_cordic
	import qr_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROWS      = 8;
	localparam int ITER_NUM  = 12;
	localparam int NUM_FIXED = 3;
	localparam int NUM_CASES = 6;
	localparam int TIMEOUT   = 2000;

	// Fixed matrices with a zero second column, all positive rows and mixed signs
	localparam int FIX_A1 [NUM_FIXED][8] = '{
		'{10, -20, 35, 7, -50, 64, 3, -1},
		'{12, 40, 7, 90, 33, 5, 61, 18},
		'{-15, 80, -100, 22, -7, 45, -60, 31}
	};
	localparam int FIX_A2 [NUM_FIXED][8] = '{
		'{0, 0, 0, 0, 0, 0, 0, 0},
		'{25, 3, 77, 14, 50, 99, 8, 42},
		'{60, -45, 12, -99, 100, -3, 27, -80}
	};

	logic      clk;
	logic      rst;
	logic      en;
	sample_t   rd_a_data = '0;
	logic      rd_a;
	mat_addr_t rd_a_addr;
	logic      wr_r;
	mat_addr_t wr_r_addr;
	sample_t   wr_r_data;
	logic      valid;

	// Stimulus and expected R for every case
	sample_t tab_a [NUM_CASES][ROWS][2];
	sample_t tab_r [NUM_CASES][3];
	logic    tab_zero [NUM_CASES];
	string   r_name [3] = '{"r11", "r12", "r22"};

	sample_t     mem [ROWS][2];
	mat_addr_t   rd_log[$];
	mat_addr_t   wr_addr_q[$];
	sample_t     wr_data_q[$];
	int          wr_cyc_q[$];
	int          cyc = 0;
	logic [31:0] rng = 32'd20;

	qr_cordic_top #(
		.ROWS     (ROWS),
		.ITER_NUM (ITER_NUM)
	) qr_cordic_top_inst (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.rd_a_data (rd_a_data),
		.rd_a      (rd_a),
		.rd_a_addr (rd_a_addr),
		.wr_r      (wr_r),
		.wr_r_addr (wr_r_addr),
		.wr_r_data (wr_r_data),
		.valid     (valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// A memory answers one cycle after the read strobe
	always @(posedge clk) begin
		if (rd_a) begin
			rd_a_data <= mem[rd_a_addr.row][rd_a_addr.col];
			rd_log.push_back(rd_a_addr);
		end
	end

	// R memory side logs every write with the cycle it was seen in
	always @(posedge clk) begin
		if (wr_r) begin
			wr_addr_q.push_back(wr_r_addr);
			wr_data_q.push_back(wr_r_data);
			wr_cyc_q.push_back(cyc);
		end
	end

	task automatic check_val(input string what, input logic signed [31:0] got,
			input logic signed [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Uniform-ish element in -100..100
	function automatic sample_t rand_elem();
		rng = xorshift32(rng);
		return sample_t'(int'(rng % 32'd201) - 100);
	endfunction

	function automatic sample_t gain_comp(input sample_t v);
		logic signed [R_LEN+K_LEN-1:0] p;
		p = v * K_VALUE;
		return p[K_FRAC+R_LEN-1:K_FRAC];
	endfunction

	task automatic rotate_pair(input logic up, input int sh, inout sample_t x,
			inout sample_t y);
		sample_t xs;
		sample_t ys;
		xs = x >>> sh;
		ys = y >>> sh;
		if (up) begin
			x = x + ys;
			y = y - xs;
		end else begin
			x = x - ys;
			y = y + xs;
		end
	endtask

	// Row by row QR with the same micro-rotations and K steps as the array
	task automatic build_expected(input int c);
		sample_t x1;
		sample_t y1;
		sample_t x2;
		sample_t y2;
		sample_t x3;
		sample_t y3;
		sample_t resid [ROWS];
		logic    up;
		x1 = '0;
		x2 = '0;
		x3 = '0;
		for (int r = 0; r < ROWS; r++) begin
			y1 = tab_a[c][r][0];
			y2 = tab_a[c][r][1];
			for (int i = 0; i < ITER_NUM; i++) begin
				up = !y1[R_LEN-1];
				rotate_pair(up, i, x1, y1);
				rotate_pair(up, i, x2, y2);
			end
			x1 = gain_comp(x1);
			y1 = gain_comp(y1);
			x2 = gain_comp(x2);
			y2 = gain_comp(y2);
			resid[r] = y2;
		end
		// Second column residuals fold into r22
		for (int r = 0; r < ROWS; r++) begin
			y3 = resid[r];
			for (int i = 0; i < ITER_NUM; i++) begin
				up = !y3[R_LEN-1];
				rotate_pair(up, i, x3, y3);
			end
			x3 = gain_comp(x3);
			y3 = gain_comp(y3);
		end
		tab_r[c][0] = x1;
		tab_r[c][1] = x2;
		tab_r[c][2] = x3;
	endtask

	task automatic build_table();
		for (int c = 0; c < NUM_CASES; c++) begin
			tab_zero[c] = (c == 0);
			for (int r = 0; r < ROWS; r++) begin
				if (c < NUM_FIXED) begin
					tab_a[c][r][0] = sample_t'(FIX_A1[c][r]);
					tab_a[c][r][1] = sample_t'(FIX_A2[c][r]);
				end else begin
					tab_a[c][r][0] = rand_elem();
					tab_a[c][r][1] = rand_elem();
				end
			end
			build_expected(c);
		end
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		while (valid !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) begin
				$display("Timeout: valid did not rise after en");
				$display("Simulation FAILED");
				$fatal(1, "timeout");
			end
		end
	endtask

	task automatic check_case(input int c);
		int idx;
		// Col 0 then col 1 for every row in order
		check_val("read count", rd_log.size(), 2 * ROWS);
		for (int r = 0; r < ROWS; r++) begin
			for (int k = 0; k < 2; k++) begin
				idx = 2 * r + k;
				check_val("read row", 32'(rd_log[idx].row), r);
				check_val("read col", 32'(rd_log[idx].col), k);
			end
		end
		check_val("write count", wr_addr_q.size(), 3);
		for (int k = 0; k < 3; k++) begin
			check_val("write row", 32'(wr_addr_q[k].row), (k == 2) ? 1 : 0);
			check_val("write col", 32'(wr_addr_q[k].col), (k == 0) ? 0 : 1);
			check_val(r_name[k], 32'(wr_data_q[k]), 32'(tab_r[c][k]));
		end
		check_val("r11 to r12 spacing", wr_cyc_q[1] - wr_cyc_q[0], 1);
		if (tab_zero[c]) begin
			check_val("r22 of zero column", 32'(wr_data_q[2]), 0);
		end
	endtask

	initial begin
		int rise_cyc;
		rst = 1'b1;
		en = 1'b0;
		build_table();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// Quiet after reset until en
		repeat (4) begin
			@(negedge clk);
			check_val("rd_a after reset", 32'(rd_a), 0);
			check_val("wr_r after reset", 32'(wr_r), 0);
			check_val("valid after reset", 32'(valid), 0);
		end
		check_val("reads before en", rd_log.size(), 0);

		for (int c = 0; c < NUM_CASES; c++) begin
			for (int r = 0; r < ROWS; r++) begin
				mem[r][0] = tab_a[c][r][0];
				mem[r][1] = tab_a[c][r][1];
			end
			rd_log.delete();
			wr_addr_q.delete();
			wr_data_q.delete();
			wr_cyc_q.delete();
			@(posedge clk);
			en <= 1'b1;
			@(posedge clk);
			en <= 1'b0;
			@(negedge clk);
			check_val("valid after en", 32'(valid), 0);
			wait_valid();
			rise_cyc = cyc;
			check_case(c);
			check_val("valid delay after r22 write", rise_cyc - wr_cyc_q[2], 1);
			repeat (2) @(negedge clk);
			check_val("valid held", 32'(valid), 1);
			check_val("writes after valid", wr_addr_q.size(), 3);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule
